//--- vlog.f
+incdir+include
source/aes_pkg.sv
source/state_serializer.sv
source/sbox_rom.sv
source/shift_rows_collector.sv
source/mix_column.sv
source/round_key_adder.sv
source/aes_round_core.sv
test/aes_round_ref_pkg.sv
test/aes_round_tb.sv

//--- Bender.yml
package:
  name: aes_round_core

export_include_dirs:
  - include

sources:
  - files:
      - source/aes_pkg.sv
      - source/state_serializer.sv
      - source/sbox_rom.sv
      - source/shift_rows_collector.sv
      - source/mix_column.sv
      - source/round_key_adder.sv
      - source/aes_round_core.sv
  - target: test
    files:
      - test/aes_round_ref_pkg.sv
      - test/aes_round_tb.sv

//--- test/aes_round_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_round_tb
    import aes_pkg::*, aes_round_ref_pkg::*;
();

    localparam int CLK_PERIOD      = 4;                         // ns.
    localparam int N_PLAIN         = 24;                        // Random non-final blocks.
    localparam int N_FINAL         = 12;                        // Random final-round blocks.
    localparam int N_STALL         = 24;                        // Blocks under out_ready stalls.
    localparam int N_BLOCKS        = 2 + N_PLAIN + N_FINAL + N_STALL;
    localparam int WATCHDOG_CYCLES = N_BLOCKS * 16 * 8 + 200;   // Stall factor 8, plus margin.
    localparam int DRAIN_CYCLES    = 3 * 16 * 8;                // Three blocks in flight.

    logic       clk;
    logic       resetn;
    logic       in_valid;
    logic       in_ready;
    aes_state_t in_state;
    aes_state_t in_round_key;
    logic       in_final;
    logic       out_valid;
    logic       out_ready;
    aes_state_t out_state;

    aes_state_t exp_q [$];                                      // Expected blocks, oldest first.
    aes_state_t exp_head  = '0;                                 // Oldest entry, seen by checks.
    int         exp_count = 0;
    int         acc_count = 0;                                  // Blocks accepted.
    int         out_count = 0;                                  // Blocks delivered.
    aes_state_t last_out  = '0;
    logic       stall_en  = 1'b0;                               // Random out_ready when set.
    logic [15:0] lfsr     = 16'd3783;                           // Seed.

    aes_round_core uut (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_state     (in_state),
        .in_round_key (in_round_key),
        .in_final     (in_final),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_state    (out_state)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failed check");
    endtask

    // Fibonacci taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [127:0] take_bits(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);                             // One step per bit.
            v    = {v[126:0], lfsr[0]};
        end
        return v;
    endfunction

    // Listings in FIPS-197 give byte 0 first.
    function automatic aes_state_t fips_state(input logic [127:0] v);
        aes_state_t s;
        for (int i = 0; i < AES_STATE_BYTES; i++)
            s[i] = v[127 - 8*i -: 8];
        return s;
    endfunction

    // Step to the next falling edge and pick out_ready.
    task automatic next_cycle();
        @(negedge clk);
        if (stall_en)
            out_ready = (take_bits(3) == 0);                    // Ready one cycle in eight.
        else
            out_ready = 1'b1;
    endtask

    // Returns on the falling edge right after the accepting edge.
    task automatic send_block(input aes_state_t st, input aes_state_t key, input logic last);
        int start;
        start        = acc_count;
        in_state     = st;
        in_round_key = key;
        in_final     = last;
        in_valid     = 1'b1;
        next_cycle();
        while (acc_count == start)
            next_cycle();
        in_valid = 1'b0;
    endtask

    // Mode 0 never final, 1 always final, 2 random.
    task automatic send_random(input int count, input int mode);
        int         gap;
        aes_state_t st;
        aes_state_t key;
        logic       fin;
        for (int n = 0; n < count; n++)
        begin
            gap = int'(take_bits(2));                           // Idle cycles on in_valid.
            repeat (gap) next_cycle();
            st  = take_bits(128);
            key = take_bits(128);
            fin = (mode == 2) ? (take_bits(1) != 0) : (mode == 1);
            send_block(st, key, fin);
        end
    endtask

    // Waits for the accepted blocks to come out, up to DRAIN_CYCLES.
    task automatic drain();
        int waited;
        waited = 0;
        while (out_count != acc_count && waited < DRAIN_CYCLES)
        begin
            next_cycle();
            waited++;
        end
    endtask

    // Scoreboard update on both handshakes.
    always @(posedge clk)
    begin
        if (resetn)
        begin
            if (out_valid && out_ready)
            begin
                if (exp_q.size() > 0)
                    void'(exp_q.pop_front());
                last_out  <= out_state;
                out_count <= out_count + 1;
            end
            if (in_valid && in_ready)
            begin
                exp_q.push_back(round_ref(in_state, in_round_key, in_final));
                acc_count <= acc_count + 1;
            end
            exp_count <= exp_q.size();
            exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        out_valid && out_ready |-> exp_count != 0)
        else abort_run("an output block was delivered with no accepted block pending");

    assert property (@(posedge clk) disable iff (!resetn)
        out_valid && out_ready |-> out_state == exp_head)
        else abort_run($sformatf("error: out_state=%h expected=%h",
                                 $sampled(out_state), $sampled(exp_head)));

    // Held output keeps its valid and its data.
    assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_state))
        else abort_run($sformatf("error: out_state=%h out_valid=%h changed while held",
                                 $sampled(out_state), $sampled(out_valid)));

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES));
    end

    initial
    begin
        int lat;
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_state     = '0;
        in_round_key = '0;
        in_final     = 1'b0;
        out_ready    = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        assert (!out_valid)
            else abort_run($sformatf("error: out_valid=%h expected=%h", out_valid, 1'b0));
        assert (in_ready)
            else abort_run($sformatf("error: in_ready=%h expected=%h", in_ready, 1'b1));

        // Appendix B, round 1.
        send_block(fips_state(128'h193de3bea0f4e22b9ac68d2ae9f84808),
                   fips_state(128'ha0fafe1788542cb123a339392a6c7605), 1'b0);
        drain();
        assert (last_out == fips_state(128'ha49c7ff2689f352b6b5bea43026a5049))
            else abort_run($sformatf("error: out_state=%h expected=%h", last_out,
                                     fips_state(128'ha49c7ff2689f352b6b5bea43026a5049)));

        // Empty pipeline. lat counts the rising edges after the accepting edge.
        send_block(take_bits(128), take_bits(128), 1'b0);
        lat = 0;
        while (!out_valid && lat < 64)
        begin
            next_cycle();
            lat++;
        end
        assert (lat == 18)
            else abort_run($sformatf("error: out_valid latency=%h expected=%h", lat, 18));
        drain();

        send_random(N_PLAIN, 0);
        send_random(N_FINAL, 1);
        stall_en = 1'b1;
        send_random(N_STALL, 2);
        stall_en = 1'b0;
        drain();
        assert (exp_q.size() == 0 && out_count == N_BLOCKS)
            else abort_run($sformatf("error: out_count=%h expected=%h", out_count, N_BLOCKS));
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/aes_round_ref_pkg.sv
`default_nettype none

package aes_round_ref_pkg;

    import aes_pkg::*;

    // Shift and add product, reduced by x^8 + x^4 + x^3 + x + 1.
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t p;
        aes_byte_t x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;                                      // Add this power of x.
            x = (x << 1) ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Multiplicative inverse by search, zero maps to zero.
    function automatic aes_byte_t gf_inv(input aes_byte_t a);
        aes_byte_t inv;
        inv = 8'h00;
        for (int b = 1; b < 256; b++)
            if (gf_mul(a, aes_byte_t'(b)) == 8'h01)
                inv = aes_byte_t'(b);
        return inv;
    endfunction

    // Inverse followed by the affine map with constant 0x63.
    function automatic aes_byte_t sbox_value(input aes_byte_t a);
        aes_byte_t inv;
        aes_byte_t s;
        inv = gf_inv(a);
        s   = 8'h63;
        for (int i = 0; i < 8; i++)
            s[i] = s[i] ^ inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                 ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        return s;
    endfunction

    // One full round, or the last round without MixColumns.
    function automatic aes_state_t round_ref(input aes_state_t st, input aes_state_t key,
                                             input logic last);
        aes_byte_t  coef [4];
        aes_state_t sr;
        aes_state_t mc;
        coef = '{8'h02, 8'h03, 8'h01, 8'h01};                   // First matrix row.
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                sr[4*c + r] = sbox_value(st[4*((c + r) % 4) + r]);  // SubBytes, ShiftRows.
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
            begin
                mc[4*c + r] = 8'h00;
                for (int k = 0; k < 4; k++)
                    mc[4*c + r] ^= gf_mul(coef[(k - r + 4) % 4], sr[4*c + k]);
            end
        return (last ? sr : mc) ^ key;                          // AddRoundKey.
    endfunction

endpackage

`default_nettype wire

//--- source/aes_round_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_round_core
    import aes_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire             in_valid,
    output logic            in_ready,
    input  wire aes_state_t in_state,                           // State before the round.
    input  wire aes_state_t in_round_key,
    input  wire             in_final,                           // Last round of a cipher.
    output logic            out_valid,
    input  wire             out_ready,
    output aes_state_t      out_state                           // State after the round.
);

    localparam int COL_BYTES = AES_STATE_BYTES / AES_COLUMNS;   // Bytes per lane.

    logic       sub_req;                                        // Serializer to ROM.
    aes_byte_t  sub_addr;
    aes_byte_t  sub_byte;                                       // ROM to collector.
    logic       sub_byte_valid;
    aes_state_t ser_key;                                        // Sideband from the serializer.
    logic       ser_final;
    aes_state_t shifted_state;                                  // Collector to lanes.
    logic       state_full;
    logic       collect_busy;
    logic       collect_ack;
    aes_state_t col_key;                                        // Sideband from the collector.
    logic       col_final;
    wire aes_state_t mixed_state;                               // Lanes to adder.

    state_serializer u_serializer (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_state     (in_state),
        .in_round_key (in_round_key),
        .in_final     (in_final),
        .in_ready     (in_ready),
        .collect_busy (collect_busy),
        .sub_req      (sub_req),
        .sub_addr     (sub_addr),
        .blk_key      (ser_key),
        .blk_final    (ser_final)
    );

    sbox_rom u_sbox (
        .clk            (clk),
        .resetn         (resetn),
        .sub_req        (sub_req),
        .sub_addr       (sub_addr),
        .sub_byte       (sub_byte),
        .sub_byte_valid (sub_byte_valid)
    );

    shift_rows_collector u_collector (
        .clk            (clk),
        .resetn         (resetn),
        .sub_byte       (sub_byte),
        .sub_byte_valid (sub_byte_valid),
        .blk_key_in     (ser_key),
        .blk_final_in   (ser_final),
        .collect_ack    (collect_ack),
        .shifted_state  (shifted_state),
        .state_full     (state_full),
        .collect_busy   (collect_busy),
        .blk_key        (col_key),
        .blk_final      (col_final)
    );

    // One MixColumns lane per column.
    for (genvar c = 0; c < AES_COLUMNS; c++)
    begin : g_lane
        mix_column u_mix (
            .col_in  (shifted_state[COL_BYTES*c +: COL_BYTES]),
            .bypass  (col_final),
            .col_out (mixed_state[COL_BYTES*c +: COL_BYTES])
        );
    end

    round_key_adder u_adder (
        .clk         (clk),
        .resetn      (resetn),
        .mixed_state (mixed_state),
        .blk_key     (col_key),
        .state_full  (state_full),
        .out_ready   (out_ready),
        .collect_ack (collect_ack),
        .out_valid   (out_valid),
        .out_state   (out_state)
    );

endmodule

`default_nettype wire

//--- source/round_key_adder.sv
`timescale 1ns/1ps
`default_nettype none

module round_key_adder
    import aes_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire aes_state_t mixed_state,                        // Lane outputs.
    input  wire aes_state_t blk_key,                            // Round key of the block.
    input  wire             state_full,                         // Collector holds a state.
    input  wire             out_ready,
    output logic            collect_ack,                        // State taken this edge.
    output logic            out_valid,
    output aes_state_t      out_state
);

    logic load;                                                 // Output register update.

    assign collect_ack = !out_valid || out_ready;               // Register empty or draining.
    assign load        = state_full && collect_ack;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            out_valid <= 1'b0;
        else
        begin
            if (load)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;                              // Block handed off.
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            out_state <= mixed_state ^ blk_key;                 // AddRoundKey.
    end

    // Output block held unchanged under back-pressure.
    assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(out_state))
        else $error("error: out_state changed while held, out_state=%h", out_state);

endmodule

`default_nettype wire

//--- source/mix_column.sv
`timescale 1ns/1ps
`default_nettype none

module mix_column
    import aes_pkg::*;
(
    input  wire aes_column_t col_in,                            // Row 0 in element 0.
    input  wire              bypass,                            // Final round skips MixColumns.
    output aes_column_t      col_out
);

    aes_column_t dbl;                                           // Each byte times 2.
    aes_column_t tpl;                                           // Each byte times 3.
    aes_column_t mixed;

    // Multiply by x in GF(2^8), reduced by x^8 + x^4 + x^3 + x + 1.
    function automatic aes_byte_t xtime(input aes_byte_t b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    always_comb
    begin
        for (int r = 0; r < AES_STATE_BYTES / AES_COLUMNS; r++)
        begin
            dbl[r] = xtime(col_in[r]);
            tpl[r] = dbl[r] ^ col_in[r];
        end
        // Circulant matrix rows 02 03 01 01.
        mixed[0] = dbl[0] ^ tpl[1] ^ col_in[2] ^ col_in[3];
        mixed[1] = col_in[0] ^ dbl[1] ^ tpl[2] ^ col_in[3];
        mixed[2] = col_in[0] ^ col_in[1] ^ dbl[2] ^ tpl[3];
        mixed[3] = tpl[0] ^ col_in[1] ^ col_in[2] ^ dbl[3];
    end

    assign col_out = bypass ? col_in : mixed;

endmodule

`default_nettype wire

//--- source/shift_rows_collector.sv
`timescale 1ns/1ps
`default_nettype none

module shift_rows_collector
    import aes_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire aes_byte_t  sub_byte,                           // Byte from the S-box ROM.
    input  wire             sub_byte_valid,
    input  wire aes_state_t blk_key_in,                         // Sideband from the serializer.
    input  wire             blk_final_in,
    input  wire             collect_ack,                        // Adder takes the state.
    output aes_state_t      shifted_state,                      // SubBytes and ShiftRows applied.
    output logic            state_full,
    output logic            collect_busy,                       // Stalls the next request.
    output aes_state_t      blk_key,
    output logic            blk_final
);

    aes_byte_idx_t wr_cnt;                                      // Bytes received of this block.
    logic [1:0]    src_row;
    logic [1:0]    src_col;
    logic [1:0]    dst_col;
    aes_byte_idx_t dst_idx;                                     // ShiftRows destination.
    logic          first_byte;
    logic          last_byte;

    assign src_row    = wr_cnt[1:0];                            // Bytes arrive in index order.
    assign src_col    = wr_cnt[3:2];
    assign dst_col    = src_col - src_row;                      // Row r rotates left by r, mod 4.
    assign dst_idx    = {dst_col, src_row};
    assign first_byte = sub_byte_valid && (wr_cnt == '0);
    assign last_byte  = sub_byte_valid && (wr_cnt == aes_byte_idx_t'(AES_STATE_BYTES - 1));

    // Stall while full and held, and also when the state completes with the adder blocked,
    // so that the byte already in the ROM never meets a held state.
    assign collect_busy = (state_full || last_byte) && !collect_ack;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_cnt     <= '0;
            state_full <= 1'b0;
        end
        else
        begin
            if (sub_byte_valid)
                wr_cnt <= wr_cnt + 1'b1;                        // Wraps to 0 after byte 15.
            if (last_byte)
                state_full <= 1'b1;                             // Visible the cycle after byte 15.
            else if (collect_ack)
                state_full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sub_byte_valid)
            shifted_state[dst_idx] <= sub_byte;
        if (first_byte)                                         // Serializer still holds this block.
        begin
            blk_key   <= blk_key_in;
            blk_final <= blk_final_in;
        end
    end

    // The serializer stall must keep bytes away from an unacknowledged full state.
    assert property (@(posedge clk) disable iff (!resetn)
        state_full && !collect_ack |-> !sub_byte_valid)
        else $error("error: sub_byte_valid while state_full held, sub_byte=%h", sub_byte);

endmodule

`default_nettype wire

//--- source/sbox_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sbox_rom
    import aes_pkg::*;
(
    input  wire            clk,
    input  wire            resetn,
    input  wire            sub_req,                             // Lookup request.
    input  wire aes_byte_t sub_addr,                            // Byte to substitute.
    output aes_byte_t      sub_byte,                            // Substituted byte.
    output logic           sub_byte_valid                       // One cycle after sub_req.
);

    `include "aes_sbox_table.svh"

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            sub_byte_valid <= 1'b0;
        else
            sub_byte_valid <= sub_req;                          // Fixed one-cycle latency.
    end

    // Registered table read.
    always_ff @(posedge clk)
    begin
        if (sub_req)
            sub_byte <= AES_SBOX_TABLE[sub_addr];
    end

endmodule

`default_nettype wire

//--- source/state_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module state_serializer
    import aes_pkg::*;
(
    input  wire             clk,
    input  wire             resetn,
    input  wire             in_valid,
    input  wire aes_state_t in_state,
    input  wire aes_state_t in_round_key,
    input  wire             in_final,
    output logic            in_ready,
    input  wire             collect_busy,                       // Collector cannot take a byte.
    output logic            sub_req,                            // Byte request to the S-box ROM.
    output aes_byte_t       sub_addr,                           // State byte at the read index.
    output aes_state_t      blk_key,                            // Round key of the loaded block.
    output logic            blk_final                           // Final-round flag of the block.
);

    aes_state_t    state_q;                                     // Loaded 16-byte state.
    logic          busy;                                        // A block is being streamed.
    aes_byte_idx_t rd_idx;                                      // Index of the byte on sub_addr.
    logic          last_req;                                    // Byte 15 goes out this cycle.
    logic          accept;                                      // Input handshake.

    assign sub_req  = busy && !collect_busy;                    // Hold while the collector is full.
    assign last_req = sub_req && (rd_idx == aes_byte_idx_t'(AES_STATE_BYTES - 1));
    assign in_ready = !busy || last_req;                        // Next block overlaps the last byte.
    assign accept   = in_valid && in_ready;
    assign sub_addr = state_q[rd_idx];                          // Byte read at the delayed index.

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy   <= 1'b0;
            rd_idx <= '0;
        end
        else
        begin
            if (accept)                                         // New block restarts at byte 0.
            begin
                busy   <= 1'b1;
                rd_idx <= '0;
            end
            else if (last_req)                                  // All 16 bytes requested.
            begin
                busy   <= 1'b0;
                rd_idx <= '0;
            end
            else if (sub_req)
                rd_idx <= rd_idx + 1'b1;                        // Index follows the request.
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)                                             // Capture block and sideband.
        begin
            state_q   <= in_state;
            blk_key   <= in_round_key;
            blk_final <= in_final;
        end
    end

    // A request run only begins after a load, or resumes once the collector frees up.
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(sub_req) |-> $past(accept) || $past(collect_busy))
        else $error("error: sub_req rose without a loaded block");

endmodule

`default_nettype wire

//--- source/aes_pkg.sv
`default_nettype none

package aes_pkg;

    // Size of one AES-128 state.
    localparam int AES_STATE_BYTES = 16;                    // Bytes per state.
    localparam int AES_COLUMNS     = 4;                     // Columns per state, one lane each.

    // One state byte.
    typedef logic [7:0] aes_byte_t;

    // Full state in FIPS-197 column-major order.
    // Byte index is four times the column plus the row.
    typedef aes_byte_t [AES_STATE_BYTES-1:0] aes_state_t;

    // One column, row 0 in element 0.
    typedef aes_byte_t [AES_STATE_BYTES/AES_COLUMNS-1:0] aes_column_t;

    // Position of a byte inside the state.
    typedef logic [$clog2(AES_STATE_BYTES)-1:0] aes_byte_idx_t;

endpackage

`default_nettype wire

//--- include/aes_sbox_table.svh
`ifndef AES_SBOX_TABLE_SVH
`define AES_SBOX_TABLE_SVH

// Forward S-box of FIPS-197 figure 7, indexed by the input byte.
localparam logic [7:0] AES_SBOX_TABLE [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,  // Inputs 0x00 to 0x07.
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,  // Inputs 0x10 to 0x17.
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,  // Inputs 0x20 to 0x27.
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,  // Inputs 0x40 to 0x47.
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,  // Inputs 0x60 to 0x67.
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,  // Inputs 0x80 to 0x87.
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,  // Inputs 0xa0 to 0xa7.
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,  // Inputs 0xc0 to 0xc7.
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,  // Inputs 0xe0 to 0xe7.
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16   // Input 0xff is the last.
};

`endif
